// File: Makefile
TOP := tb_uart_mem_bridge

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -f project.f --top-module $(TOP)
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing -f project.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// File: project.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/mem_bridge_pkg.sv
rtl/byte_link_if.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/byte_counter.sv
rtl/word_shifter.sv
rtl/mem_bridge_fsm.sv
rtl/uart_mem_bridge.sv
tb/uart_mem_bridge_sva.sv
tb/tb_uart_mem_bridge.sv

// File: rtl/byte_counter.sv
`timescale 1ns/1ps
`include "uart_mem_cfg.svh"

module byte_counter (
    input  logic clk,
    input  logic arst_n,
    input  logic clear,
    input  logic step,
    output logic last
);

    localparam int N  = `BRIDGE_WORD_BYTES;
    localparam int IW = $clog2(N);

    logic [IW-1:0] idx;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            idx <= '0;
        end else if (clear) begin
            idx <= '0;
        end else if (step) begin
            idx <= last ? '0 : idx + 1'b1; // Wraps, ready for the next phase.
        end
    end

    assign last = (idx == IW'(N - 1));

endmodule

// File: rtl/byte_link_if.sv
`timescale 1ns/1ps

interface byte_link_if;
    import uart_pkg::*;

    logic  tx_start; // One-cycle strobe, only while tx_ready.
    byte_t tx_byte;
    logic  tx_ready; // High while the transmitter is idle.
    byte_t rx_byte;
    logic  rx_valid; // One-cycle pulse per good byte.

    modport ctrl (
        output tx_start,
        input  tx_ready,
        input  rx_valid,
        input  rx_byte
    );

    modport tx (
        input  tx_start,
        input  tx_byte,
        output tx_ready
    );

    modport rx (
        output rx_byte,
        output rx_valid
    );

endinterface

// File: rtl/mem_bridge_fsm.sv
`timescale 1ns/1ps

module mem_bridge_fsm (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            cmd_start,
    input  logic            cmd_write,
    output logic            cmd_ready,
    output logic            rdata_valid,
    byte_link_if.ctrl       link,
    output logic            op_phase,
    output uart_pkg::byte_t op_byte,
    output logic            cnt_clear,
    output logic            cnt_step,
    input  logic            cnt_last,
    output logic            load_addr,
    output logic            load_data,
    output logic            shift_out,
    output logic            shift_in
);
    import mem_bridge_pkg::*;

    bridge_state_t state;
    bridge_state_t state_nxt;
    opcode_t       op_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= st_idle;
            op_q  <= op_read;
        end else begin
            state <= state_nxt;
            if (load_addr) begin
                op_q <= cmd_write ? op_write : op_read;
            end
        end
    end

    always_comb begin
        state_nxt     = state;
        link.tx_start = 1'b0;
        cnt_clear     = 1'b0;
        cnt_step      = 1'b0;
        load_addr     = 1'b0;
        load_data     = 1'b0;
        shift_out     = 1'b0;
        shift_in      = 1'b0;
        case (state)
            st_idle: begin
                if (cmd_start) begin
                    load_addr = 1'b1; // Address is valid only in this cycle.
                    cnt_clear = 1'b1;
                    state_nxt = st_send_op;
                end
            end
            st_send_op: begin
                if (link.tx_ready) begin
                    link.tx_start = 1'b1;
                    state_nxt     = st_wait_op;
                end
            end
            st_wait_op: state_nxt = st_send_addr;
            st_send_addr: begin
                if (link.tx_ready) begin
                    link.tx_start = 1'b1;
                    state_nxt     = st_wait_addr;
                end
            end
            st_wait_addr: begin
                shift_out = 1'b1;
                cnt_step  = 1'b1;
                if (!cnt_last) begin
                    state_nxt = st_send_addr;
                end else if (op_q == op_write) begin
                    load_data = 1'b1;
                    state_nxt = st_send_data;
                end else begin
                    state_nxt = st_recv;
                end
            end
            st_send_data: begin
                if (link.tx_ready) begin
                    link.tx_start = 1'b1;
                    state_nxt     = st_wait_data;
                end
            end
            st_wait_data: begin
                shift_out = 1'b1;
                cnt_step  = 1'b1;
                state_nxt = cnt_last ? st_done : st_send_data;
            end
            st_recv: begin
                if (link.rx_valid) begin
                    shift_in = 1'b1;
                    cnt_step = 1'b1;
                    if (cnt_last) begin
                        state_nxt = st_done;
                    end
                end
            end
            st_done: begin
                // A write waits for the last stop bit to leave the line.
                if (op_q == op_read || link.tx_ready) begin
                    state_nxt = st_idle;
                end
            end
            default: state_nxt = st_idle;
        endcase
    end

    assign cmd_ready   = (state == st_idle);
    assign rdata_valid = (state == st_done) && (op_q == op_read);
    assign op_phase    = (state == st_send_op);
    assign op_byte     = op_q;

endmodule

// File: rtl/mem_bridge_pkg.sv
package mem_bridge_pkg;

    // Address or data word of the remote memory.
    typedef logic [31:0] word_t;

    // Opcode byte sent at the head of every command.
    typedef enum logic [7:0] {
        op_read  = 8'h00,
        op_write = 8'h01
    } opcode_t;

    typedef enum logic [3:0] {
        st_idle,
        st_send_op,   // Opcode byte.
        st_wait_op,
        st_send_addr, // Four address bytes.
        st_wait_addr,
        st_send_data, // Four write data bytes.
        st_wait_data,
        st_recv,      // Four reply bytes.
        st_done
    } bridge_state_t;

endpackage

// File: rtl/uart_mem_bridge.sv
`timescale 1ns/1ps

module uart_mem_bridge (
    input  logic                  clk,
    input  logic                  arst_n,
    input  logic                  uart_rx,
    output logic                  uart_tx,
    input  logic                  cmd_start,
    input  logic                  cmd_write,
    output logic                  cmd_ready,
    input  mem_bridge_pkg::word_t addr,
    input  mem_bridge_pkg::word_t wdata,
    output mem_bridge_pkg::word_t rdata,
    output logic                  rdata_valid
);
    import uart_pkg::*;

    byte_link_if link ();

    logic  op_phase;
    byte_t op_byte;
    byte_t out_byte;
    logic  cnt_clear;
    logic  cnt_step;
    logic  cnt_last;
    logic  load_addr;
    logic  load_data;
    logic  shift_out;
    logic  shift_in;

    assign link.tx_byte = op_phase ? op_byte : out_byte; // Opcode first, then word bytes.

    mem_bridge_fsm u_fsm (
        .clk         (clk),
        .arst_n      (arst_n),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .rdata_valid (rdata_valid),
        .link        (link),
        .op_phase    (op_phase),
        .op_byte     (op_byte),
        .cnt_clear   (cnt_clear),
        .cnt_step    (cnt_step),
        .cnt_last    (cnt_last),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .shift_out   (shift_out),
        .shift_in    (shift_in)
    );

    byte_counter u_counter (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (cnt_clear),
        .step   (cnt_step),
        .last   (cnt_last)
    );

    word_shifter u_shifter (
        .clk       (clk),
        .arst_n    (arst_n),
        .addr      (addr),
        .wdata     (wdata),
        .load_addr (load_addr),
        .load_data (load_data),
        .shift_out (shift_out),
        .shift_in  (shift_in),
        .rx_byte   (link.rx_byte),
        .out_byte  (out_byte),
        .rdata     (rdata)
    );

    uart_tx u_uart_tx (
        .clk     (clk),
        .arst_n  (arst_n),
        .link    (link),
        .uart_tx (uart_tx)
    );

    uart_rx u_uart_rx (
        .clk     (clk),
        .arst_n  (arst_n),
        .uart_rx (uart_rx),
        .link    (link)
    );

endmodule

// File: rtl/uart_mem_cfg.svh
`ifndef UART_MEM_CFG_SVH
`define UART_MEM_CFG_SVH

// Serial line timing.
// Clocks per UART bit; both ends of the link must agree on it.
`define UART_CLKS_PER_BIT 8

// Memory word geometry.
// Bytes per address or data word, sent most significant first.
`define BRIDGE_WORD_BYTES 4

`endif

// File: rtl/uart_pkg.sv
package uart_pkg;

    // One UART payload byte.
    typedef logic [7:0] byte_t;

    // Phase of a single 8N1 frame.
    typedef enum logic [1:0] {
        ph_idle,  // Line high, no frame.
        ph_start, // Low start bit.
        ph_data,  // Eight data bits, LSB first.
        ph_stop   // High stop bit.
    } uart_phase_t;

endpackage

// File: rtl/uart_rx.sv
`timescale 1ns/1ps
`include "uart_mem_cfg.svh"

module uart_rx (
    input  logic    clk,
    input  logic    arst_n,
    input  logic    uart_rx,
    byte_link_if.rx link
);
    import uart_pkg::*;

    localparam int CPB  = `UART_CLKS_PER_BIT;
    localparam int HALF = CPB / 2;
    localparam int TW   = $clog2(CPB);

    logic          rx_meta;
    logic          rx_sync;
    logic          rx_prev;
    uart_phase_t   phase;
    logic [TW-1:0] timer;
    logic [2:0]    bit_idx;
    byte_t         shreg;
    logic          bit_end;
    logic          mid_start;
    logic          fall;

    assign bit_end   = (timer == TW'(CPB - 1));
    assign mid_start = (timer == TW'(HALF - 1));
    assign fall      = rx_prev & ~rx_sync;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= uart_rx;
            rx_sync <= rx_meta;
            rx_prev <= rx_sync;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase         <= ph_idle;
            timer         <= '0;
            bit_idx       <= '0;
            link.rx_valid <= 1'b0;
        end else begin
            link.rx_valid <= 1'b0;
            timer         <= bit_end ? '0 : timer + 1'b1;
            case (phase)
                ph_idle: begin
                    timer <= '0;
                    if (fall) begin
                        phase <= ph_start;
                    end
                end
                ph_start: begin
                    if (mid_start) begin
                        timer <= '0;
                        phase <= rx_sync ? ph_idle : ph_data; // Glitch check at half bit.
                        bit_idx <= '0;
                    end
                end
                ph_data: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin
                            phase <= ph_stop;
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        phase         <= ph_idle;
                        link.rx_valid <= rx_sync; // Low stop bit drops the byte.
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_data && bit_end) begin
            shreg <= {rx_sync, shreg[7:1]};
        end
        if (phase == ph_stop && bit_end) begin
            link.rx_byte <= shreg;
        end
    end

endmodule

// File: rtl/uart_tx.sv
`timescale 1ns/1ps
`include "uart_mem_cfg.svh"

module uart_tx (
    input  logic    clk,
    input  logic    arst_n,
    byte_link_if.tx link,
    output logic    uart_tx
);
    import uart_pkg::*;

    localparam int CPB = `UART_CLKS_PER_BIT;
    localparam int TW  = $clog2(CPB);

    uart_phase_t   phase;
    logic [TW-1:0] timer;
    logic [2:0]    bit_idx;
    byte_t         shreg;
    logic          bit_end;

    assign bit_end       = (timer == TW'(CPB - 1));
    assign link.tx_ready = (phase == ph_idle);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase   <= ph_idle;
            timer   <= '0;
            bit_idx <= '0;
            uart_tx <= 1'b1; // Line idles high.
        end else begin
            if (phase != ph_idle) begin
                timer <= bit_end ? '0 : timer + 1'b1;
            end
            case (phase)
                ph_idle: begin
                    if (link.tx_start) begin
                        phase   <= ph_start;
                        timer   <= '0;
                        uart_tx <= 1'b0;
                    end
                end
                ph_start: begin
                    if (bit_end) begin
                        phase   <= ph_data;
                        bit_idx <= '0;
                        uart_tx <= shreg[0];
                    end
                end
                ph_data: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            phase   <= ph_stop;
                            uart_tx <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            uart_tx <= shreg[1]; // Next bit, shreg shifts on this edge.
                        end
                    end
                end
                default: begin
                    if (bit_end) begin
                        phase <= ph_idle;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (phase == ph_idle && link.tx_start) begin
            shreg <= link.tx_byte;
        end else if (phase == ph_data && bit_end) begin
            shreg <= {1'b0, shreg[7:1]};
        end
    end

endmodule

// File: rtl/word_shifter.sv
`timescale 1ns/1ps
`include "uart_mem_cfg.svh"

module word_shifter (
    input  logic                  clk,
    input  logic                  arst_n,
    input  mem_bridge_pkg::word_t addr,
    input  mem_bridge_pkg::word_t wdata,
    input  logic                  load_addr,
    input  logic                  load_data,
    input  logic                  shift_out,
    input  logic                  shift_in,
    input  uart_pkg::byte_t       rx_byte,
    output uart_pkg::byte_t       out_byte,
    output mem_bridge_pkg::word_t rdata
);
    import mem_bridge_pkg::*;

    localparam int WB = `BRIDGE_WORD_BYTES * 8;

    word_t word_q;

    // Outgoing word, most significant byte on top.
    always_ff @(posedge clk) begin
        if (load_addr) begin
            word_q <= addr;
        end else if (load_data) begin
            word_q <= wdata; // Wins over the shift of the last address byte.
        end else if (shift_out) begin
            word_q <= word_q << 8;
        end
    end

    assign out_byte = word_q[WB-1 -: 8];

    // Reply bytes enter at the bottom.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (shift_in) begin
            rdata <= {rdata[WB-9:0], rx_byte};
        end
    end

endmodule

// File: tb/tb_uart_mem_bridge.sv
`timescale 1ns/1ps
`include "uart_mem_cfg.svh"

module tb_uart_mem_bridge;
    import uart_pkg::*;
    import mem_bridge_pkg::*;

    localparam int CPB         = `UART_CLKS_PER_BIT;
    localparam int NB          = `BRIDGE_WORD_BYTES;
    localparam int MAX_GAP     = 40;
    localparam int N_RANDOM    = 40;
    localparam int N_CMDS      = N_RANDOM + 4;
    localparam int CMD_CYCLES  = (2 * NB + 1 + NB + 1) * 10 * CPB + MAX_GAP + 60;
    localparam int WATCHDOG_NS = (N_CMDS * CMD_CYCLES + 400) * 10;

    logic  clk;
    logic  arst_n;
    logic  uart_rx;
    logic  uart_tx;
    logic  cmd_start;
    logic  cmd_write;
    logic  cmd_ready;
    word_t addr;
    word_t wdata;
    word_t rdata;
    logic  rdata_valid;

    int    seed = 32'h2178;
    string test_name = "reset";
    byte_t got_bytes [$]; // Frames seen on uart_tx, for the compare process.
    byte_t mem_bytes [$]; // Same frames, for the remote memory.
    byte_t exp_bytes [$];
    word_t exp_rdata [$];
    word_t shadow [16];
    word_t last_rdata;
    bit    have_rdata;

    uart_mem_bridge uart_mem_bridge_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .uart_rx     (uart_rx),
        .uart_tx     (uart_tx),
        .cmd_start   (cmd_start),
        .cmd_write   (cmd_write),
        .cmd_ready   (cmd_ready),
        .addr        (addr),
        .wdata       (wdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    bind uart_mem_bridge uart_mem_bridge_sva u_sva (
        .clk         (clk),
        .arst_n      (arst_n),
        .uart_tx     (uart_tx),
        .cmd_ready   (cmd_ready),
        .rdata_valid (rdata_valid),
        .tx_start    (link.tx_start),
        .tx_ready    (link.tx_ready),
        .state       (u_fsm.state)
    );

    function automatic word_t fill_word(input int idx);
        return word_t'(32'h5A00_00A5 ^ (idx * 32'h0101_0101));
    endfunction

    // Opcode, then address and write data, most significant byte first.
    function automatic int expected_frames(input bit wr, input word_t a, input word_t d,
                                           output byte_t frames [2*NB+1]);
        int n;
        frames = '{default: 8'h00};
        frames[0] = wr ? op_write : op_read;
        n = 1;
        for (int i = NB - 1; i >= 0; i--) begin
            frames[n] = a[8*i +: 8];
            n++;
        end
        if (wr) begin
            for (int i = NB - 1; i >= 0; i--) begin
                frames[n] = d[8*i +: 8];
                n++;
            end
        end
        return n;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    task automatic check_byte(input string name, input byte_t expected, input byte_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected 8'h%02h, actual 8'h%02h",
                                name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("ERROR %s: expected 32'h%08h, actual 32'h%08h",
                                name, expected, actual));
        end
    endtask

    // Samples on the falling clock edge, mid bit.
    task automatic receive_frame(output byte_t b);
        b = '0;
        do begin
            @(negedge clk);
        end while (uart_tx !== 1'b0);
        repeat (CPB / 2) @(negedge clk);
        if (uart_tx !== 1'b0) begin
            abort_run("Start bit on uart_tx did not last to mid bit");
        end
        for (int i = 0; i < 8; i++) begin
            repeat (CPB) @(negedge clk);
            b[i] = uart_tx;
        end
        repeat (CPB) @(negedge clk);
        if (uart_tx !== 1'b1) begin
            abort_run("Stop bit on uart_tx was low");
        end
    endtask

    task automatic send_frame(input byte_t b);
        logic [9:0] bits;
        bits = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            uart_rx = bits[i];
            repeat (CPB) @(posedge clk);
            #1;
        end
    endtask

    task automatic pop_remote_byte(output byte_t b);
        while (mem_bytes.size() == 0) begin
            @(negedge clk);
        end
        b = mem_bytes.pop_front();
    endtask

    task automatic issue_cmd(input string name, input bit wr, input word_t a, input word_t d,
                             input bit stray);
        byte_t frames [2*NB+1];
        int    n;
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
        end
        if (have_rdata) begin
            check_word({name, " rdata hold"}, last_rdata, rdata);
        end
        test_name = name;
        n = expected_frames(wr, a, d, frames);
        for (int i = 0; i < n; i++) begin
            exp_bytes.push_back(frames[i]);
        end
        if (wr) begin
            shadow[a[3:0]] = d;
        end else begin
            exp_rdata.push_back(shadow[a[3:0]]);
        end
        cmd_start = 1'b1;
        cmd_write = wr;
        addr      = a;
        wdata     = d; // Held until cmd_ready returns.
        @(posedge clk);
        #1;
        cmd_start = 1'b0;
        addr      = $random(seed);
        cmd_write = addr[0];
        check_bit({name, " cmd_ready low"}, 1'b0, cmd_ready);
        if (stray) begin
            repeat (20) @(posedge clk);
            #1;
            cmd_start = 1'b1; // Must be ignored while busy.
            cmd_write = ~wr;
            addr      = ~a;
            @(posedge clk);
            #1;
            cmd_start = 1'b0;
        end
        while (!cmd_ready) begin
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout, the bridge hung before all commands finished");
    end

    initial begin : remote_line
        byte_t b;
        forever begin
            receive_frame(b);
            got_bytes.push_back(b);
            mem_bytes.push_back(b);
        end
    end

    initial begin : remote_memory
        word_t mem [16];
        byte_t op;
        byte_t b;
        word_t a;
        word_t d;
        int    gap;
        for (int i = 0; i < 16; i++) begin
            mem[i] = fill_word(i);
        end
        forever begin
            pop_remote_byte(op);
            a = '0;
            repeat (NB) begin
                pop_remote_byte(b);
                a = {a[23:0], b};
            end
            if (op == op_write) begin
                d = '0;
                repeat (NB) begin
                    pop_remote_byte(b);
                    d = {d[23:0], b};
                end
                mem[a[3:0]] = d;
            end else begin
                gap = int'($unsigned($random(seed)) % (MAX_GAP + 1));
                repeat (gap + 1) @(posedge clk);
                #1;
                for (int i = NB - 1; i >= 0; i--) begin
                    send_frame(mem[a[3:0]][8*i +: 8]);
                end
            end
        end
    end

    initial begin : compare
        byte_t got;
        word_t exp_word;
        forever begin
            @(negedge clk);
            if (uart_mem_bridge_i.u_sva.fail_count != 0) begin
                abort_run("A bound assertion on the bridge failed");
            end
            if (rdata_valid) begin
                if (exp_rdata.size() == 0) begin
                    abort_run("rdata_valid pulsed with no read pending");
                end else begin
                    exp_word   = exp_rdata.pop_front();
                    last_rdata = exp_word;
                    have_rdata = 1'b1;
                    check_word({test_name, " rdata"}, exp_word, rdata);
                end
            end
            while (got_bytes.size() != 0) begin
                got = got_bytes.pop_front();
                if (exp_bytes.size() == 0) begin
                    abort_run("uart_tx sent a frame that no command asked for");
                end else begin
                    check_byte({test_name, " frame"}, exp_bytes.pop_front(), got);
                end
            end
        end
    end

    initial begin : driver
        word_t a;
        word_t d;
        arst_n     = 1'b1;
        uart_rx    = 1'b1;
        cmd_start  = 1'b0;
        cmd_write  = 1'b0;
        addr       = '0;
        wdata      = '0;
        have_rdata = 1'b0;
        for (int i = 0; i < 16; i++) begin
            shadow[i] = fill_word(i);
        end
        #1;
        arst_n = 1'b0; // A real falling edge applies the asynchronous reset.
        repeat (10) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (3 * 10 * CPB) begin
            @(posedge clk);
            #1;
            check_bit("reset cmd_ready", 1'b1, cmd_ready);
            check_bit("reset rdata_valid", 1'b0, rdata_valid);
            check_bit("reset uart_tx", 1'b1, uart_tx);
        end
        issue_cmd("write", 1'b1, 32'h1234_5673, 32'hDEAD_BEEF, 1'b0);
        issue_cmd("read", 1'b0, 32'h1234_5673, '0, 1'b0);
        issue_cmd("busy write", 1'b1, 32'h0000_00A9, 32'h0BAD_F00D, 1'b1);
        issue_cmd("busy read", 1'b0, 32'hFFFF_FFF9, '0, 1'b1);
        for (int i = 0; i < N_RANDOM; i++) begin
            a = $random(seed);
            d = $random(seed);
            issue_cmd($sformatf("random %0d", i), a[31], a, d, 1'b0);
        end
        repeat (20) @(posedge clk);
        if (exp_bytes.size() != 0 || got_bytes.size() != 0 || exp_rdata.size() != 0) begin
            abort_run("Frames or read data were still pending at the end of the run");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: tb/uart_mem_bridge_sva.sv
`timescale 1ns/1ps

module uart_mem_bridge_sva (
    input logic                          clk,
    input logic                          arst_n,
    input logic                          uart_tx,
    input logic                          cmd_ready,
    input logic                          rdata_valid,
    input logic                          tx_start,
    input logic                          tx_ready,
    input mem_bridge_pkg::bridge_state_t state
);
    import mem_bridge_pkg::*;

    int fail_count = 0; // Watched by the testbench.

    line_high_in_reset: assert property (@(posedge clk) !arst_n |-> uart_tx)
        else begin
            $error("uart_tx is low while arst_n is low");
            fail_count++;
        end

    rdata_valid_single: assert property (@(posedge clk) disable iff (!arst_n)
        rdata_valid |=> !rdata_valid)
        else begin
            $error("rdata_valid lasted more than one cycle");
            fail_count++;
        end

    tx_start_when_ready: assert property (@(posedge clk) disable iff (!arst_n)
        tx_start |-> tx_ready)
        else begin
            $error("tx_start raised while tx_ready is low");
            fail_count++;
        end

    busy_not_ready: assert property (@(posedge clk) disable iff (!arst_n)
        (state != st_idle) |-> !cmd_ready)
        else begin
            $error("cmd_ready high outside st_idle");
            fail_count++;
        end

endmodule
